//--- src/busBridge_defines.svh
`ifndef BUSBRIDGE_DEFINES_SVH
`define BUSBRIDGE_DEFINES_SVH

////////////////////////////////////////
// Synchronizer depths
////////////////////////////////////////

`define C_SYNC_DEPTH    3   // C1/C3 sample history
`define DBR_SYNC_DEPTH  2   // DBRn double flop

////////////////////////////////////////
// E clock shape, counted in C1 periods
////////////////////////////////////////

`define E_DIV   5   // One E period
`define E_HIGH  2   // E high time at the end of the period

`endif

//--- src/busBridgePkg.sv
`include "busBridge_defines.svh"

package busBridgePkg;

    typedef logic [`C_SYNC_DEPTH-1:0]   phaseSync_t; // Newest sample in bit 0
    typedef logic [`DBR_SYNC_DEPTH-1:0] dbrSync_t;
    typedef logic [2:0]                 eDiv_t;

    // One engine's view of the motherboard bus
    typedef struct packed {
        logic asn;
        logic udsn;
        logic ldsn;
        logic tack;  // Active high, one CLK80 wide
    } busStrobes_t;

    typedef enum logic [2:0] {
        regIdle, regS2, regS4, regWait, regS5, regS6, regS7
    } regState_t;

    typedef enum logic [2:0] {
        cIdle, cAssert, cWaitRise, cWaitFall, cEnd
    } cState_t;

    // Returns {uds, lds}; byte writes pick one half, everything else both
    function automatic logic [1:0] strobeSel(input logic rnw, input logic siz0, input logic a0);
        return {rnw || !siz0 || !a0, rnw || !siz0 || a0};
    endfunction

endpackage

//--- src/regCycleSm.sv
`timescale 1ns/1ns

module regCycleSm
    import busBridgePkg::*;
(
    input  logic        CLK80,
    input  logic        RESETn,
    input  logic        TSn,
    input  logic        REGSPACEn,
    input  logic        RnW,
    input  logic        DBRn,
    input  logic        A0,
    input  logic        SIZ0,
    input  logic        C1,
    input  logic        C3,
    output busStrobes_t regBus,
    output logic        REGENn,
    output logic        REG_CYCLE
);

    phaseSync_t c1Sync;
    phaseSync_t c3Sync;
    dbrSync_t   dbrSync;
    regState_t  state;

    logic pending;   // Register start waiting for the FSM
    logic accept;
    logic dsEn;
    logic regTack;
    logic udsOut;
    logic ldsOut;

    logic c1LowC3Fall;
    logic c1HighC3Rise;
    logic bothHigh;
    logic bothLow;
    logic c1Rise;

    ////////////////////////////////////////
    // Quadrature phase points
    ////////////////////////////////////////

    assign c1LowC3Fall  = (c1Sync == 3'b000) && (c3Sync == 3'b110);
    assign c1HighC3Rise = (c1Sync == 3'b111) && (c3Sync == 3'b001);
    assign bothHigh     = (c1Sync == 3'b111) && (c3Sync == 3'b111);
    assign bothLow      = (c1Sync == 3'b000) && (c3Sync == 3'b000);
    assign c1Rise       = (c1Sync == 3'b011) && (c3Sync == 3'b000);

    assign accept = (state == regIdle) && pending;

    assign regBus.asn  = REGENn;               // AS tracks the Agnus enable
    assign regBus.udsn = ~(udsOut && dsEn);
    assign regBus.ldsn = ~(ldsOut && dsEn);
    assign regBus.tack = regTack;

    ////////////////////////////////////////
    // MC68000 style register cycle
    ////////////////////////////////////////

    always_ff @(negedge CLK80) begin
        if (!RESETn) begin
            c1Sync    <= '1;
            c3Sync    <= '1;
            dbrSync   <= '1;
            pending   <= 1'b0;
            state     <= regIdle;
            dsEn      <= 1'b0;
            regTack   <= 1'b0;
            REGENn    <= 1'b1;
            REG_CYCLE <= 1'b0;
        end else begin
            c1Sync  <= {c1Sync[$bits(phaseSync_t)-2:0], C1};
            c3Sync  <= {c3Sync[$bits(phaseSync_t)-2:0], C3};
            dbrSync <= {dbrSync[$bits(dbrSync_t)-2:0], DBRn};

            // A start during a running cycle is kept until idle
            pending <= (!TSn && !REGSPACEn) || (pending && !accept);

            case (state)
                regIdle: if (pending) state <= regS2;
                regS2: begin
                    if (c1LowC3Fall) begin
                        REGENn <= 1'b0;
                        dsEn   <= RnW;            // Reads strobe early
                        state  <= regS4;
                    end
                end
                regS4: begin
                    if (c1HighC3Rise) begin
                        dsEn  <= 1'b1;            // Writes strobe here
                        state <= regWait;
                    end
                end
                regWait: begin
                    // Wait states while Agnus holds DBRn
                    if (bothHigh && dbrSync == '1) begin
                        REG_CYCLE <= 1'b1;
                        state     <= regS5;
                    end
                end
                regS5: begin
                    if (bothHigh) begin
                        regTack <= 1'b1;          // Read data is latched early
                        state   <= regS6;
                    end
                end
                regS6: begin
                    regTack   <= 1'b0;
                    REG_CYCLE <= 1'b0;
                    if (bothLow) state <= regS7;
                end
                regS7: begin
                    if (c1Rise) begin
                        dsEn   <= 1'b0;
                        REGENn <= 1'b1;
                        state  <= regIdle;
                    end
                end
                default: state <= regIdle;
            endcase
        end
    end

    // Strobe halves picked when REGENn falls
    always_ff @(negedge CLK80) begin
        if (state == regS2 && c1LowC3Fall) begin
            {udsOut, ldsOut} <= strobeSel(RnW, SIZ0, A0);
        end
    end

endmodule

//--- src/eClockCycleSm.sv
`timescale 1ns/1ns
`include "busBridge_defines.svh"

module eClockCycleSm
    import busBridgePkg::*;
(
    input  logic        CLK80,
    input  logic        RESETn,
    input  logic        TSn,
    input  logic        CIASPACEn,
    input  logic        RnW,
    input  logic        A0,
    input  logic        SIZ0,
    input  logic        C1,
    output busStrobes_t ciaBus,
    output logic        VMAn,
    output logic        ECLK
);

    phaseSync_t c1Sync;
    eDiv_t      eCount;
    eDiv_t      eNext;
    cState_t    state;

    logic c1Rise;
    logic eFall;     // ECLK drops on this same edge
    logic pending;
    logic accept;
    logic ciaTack;
    logic udsOut;
    logic ldsOut;

    assign c1Rise = (c1Sync == 3'b011);
    assign eNext  = (eCount == `E_DIV - 1) ? '0 : eCount + 1'b1;
    assign eFall  = c1Rise && (eCount == `E_DIV - 1);
    assign accept = (state == cIdle) && pending;

    assign ciaBus.asn  = VMAn;
    assign ciaBus.udsn = VMAn || !udsOut;
    assign ciaBus.ldsn = VMAn || !ldsOut;
    assign ciaBus.tack = ciaTack;

    ////////////////////////////////////////
    // E clock, high for the last E_HIGH C1 periods
    ////////////////////////////////////////

    always_ff @(negedge CLK80) begin
        if (!RESETn) begin
            c1Sync <= '1;
            eCount <= '0;
            ECLK   <= 1'b0;
        end else begin
            c1Sync <= {c1Sync[$bits(phaseSync_t)-2:0], C1};
            if (c1Rise) begin
                eCount <= eNext;
                ECLK   <= (eNext >= `E_DIV - `E_HIGH);
            end
        end
    end

    ////////////////////////////////////////
    // CIA cycle framed on E
    ////////////////////////////////////////

    always_ff @(negedge CLK80) begin
        if (!RESETn) begin
            pending <= 1'b0;
            state   <= cIdle;
            VMAn    <= 1'b1;
            ciaTack <= 1'b0;
        end else begin
            pending <= (!TSn && !CIASPACEn) || (pending && !accept);
            case (state)
                cIdle:     if (pending) state <= cAssert;
                cAssert: begin
                    if (!ECLK) begin
                        VMAn  <= 1'b0;            // AS and strobes go with VMA
                        state <= cWaitRise;
                    end
                end
                cWaitRise: if (ECLK) state <= cWaitFall;
                cWaitFall: begin
                    if (eFall) begin
                        ciaTack <= 1'b1;
                        state   <= cEnd;
                    end
                end
                cEnd: begin
                    ciaTack <= 1'b0;
                    VMAn    <= 1'b1;
                    state   <= cIdle;
                end
                default: state <= cIdle;
            endcase
        end
    end

    always_ff @(negedge CLK80) begin
        if (state == cAssert && !ECLK) {udsOut, ldsOut} <= strobeSel(RnW, SIZ0, A0);
    end

endmodule

//--- src/busMerge.sv
`timescale 1ns/1ns

module busMerge
    import busBridgePkg::*;
(
    input  logic        CLK80,
    input  logic        RESETn,
    input  busStrobes_t regBus,
    input  busStrobes_t ciaBus,
    output logic        ASn,
    output logic        UDSn,
    output logic        LDSn,
    output logic        TACK
);

    busStrobes_t merged;

    // Only one engine owns the bus, so a plain AND of the lows is enough
    assign merged.asn  = regBus.asn  && ciaBus.asn;
    assign merged.udsn = regBus.udsn && ciaBus.udsn;
    assign merged.ldsn = regBus.ldsn && ciaBus.ldsn;
    assign merged.tack = regBus.tack || ciaBus.tack;

    ////////////////////////////////////////
    // Pin register, one CLK80 behind the engines
    ////////////////////////////////////////

    always_ff @(negedge CLK80) begin
        if (!RESETn) begin
            ASn  <= 1'b1;
            UDSn <= 1'b1;
            LDSn <= 1'b1;
            TACK <= 1'b0;
        end else begin
            ASn  <= merged.asn;
            UDSn <= merged.udsn;
            LDSn <= merged.ldsn;
            TACK <= merged.tack;    // Pulse of whichever engine finished
        end
    end

endmodule

//--- src/busBridgeTop.sv
`timescale 1ns/1ns

module busBridgeTop
    import busBridgePkg::*;
(
    input  logic CLK80,
    input  logic RESETn,
    input  logic TSn,
    input  logic REGSPACEn,
    input  logic CIASPACEn,
    input  logic RnW,
    input  logic DBRn,
    input  logic A0,
    input  logic SIZ0,
    input  logic C1,
    input  logic C3,
    output logic ASn,
    output logic UDSn,
    output logic LDSn,
    output logic REGENn,
    output logic VMAn,
    output logic ECLK,
    output logic TACK,
    output logic REG_CYCLE
);

    busStrobes_t regBus;  // Agnus register engine
    busStrobes_t ciaBus;  // E clock engine

    regCycleSm uRegSm (
        .CLK80, .RESETn, .TSn, .REGSPACEn, .RnW, .DBRn, .A0, .SIZ0, .C1, .C3,
        .regBus, .REGENn, .REG_CYCLE
    );

    eClockCycleSm uCiaSm (
        .CLK80, .RESETn, .TSn, .CIASPACEn, .RnW, .A0, .SIZ0, .C1,
        .ciaBus, .VMAn, .ECLK
    );

    busMerge uMerge (
        .CLK80,
        .RESETn,
        .regBus,
        .ciaBus,
        .ASn,
        .UDSn,
        .LDSn,
        .TACK
    );

endmodule

//--- testbench/busBridge_props.sv
`timescale 1ns/1ns

module busBridge_props (
    input logic CLK80,
    input logic RESETn,
    input logic ASn,
    input logic UDSn,
    input logic LDSn,
    input logic REGENn,
    input logic VMAn,
    input logic TACK,
    input logic REG_CYCLE
);

    // Termination is a single CLK80 pulse
    tackPulse: assert property (@(posedge CLK80) disable iff (!RESETn) TACK |=> !TACK)
        else $error("TACK stayed high for more than one cycle");

    enableExclusive: assert property (@(posedge CLK80) disable iff (!RESETn) REGENn || VMAn)
        else $error("REGENn and VMAn low together");   // Agnus and CIA never share a cycle

    strobeInAs: assert property (@(posedge CLK80) disable iff (!RESETn) ASn |-> (UDSn && LDSn))
        else $error("Data strobe active while ASn is high");

    // Agnus data phase sits inside the enable
    regCycleInEnable: assert property (@(posedge CLK80) disable iff (!RESETn) REG_CYCLE |-> !REGENn)
        else $error("REG_CYCLE high while REGENn is high");

endmodule

bind busBridgeTop busBridge_props uProps (
    .CLK80(CLK80), .RESETn(RESETn), .ASn(ASn), .UDSn(UDSn), .LDSn(LDSn),
    .REGENn(REGENn), .VMAn(VMAn), .TACK(TACK), .REG_CYCLE(REG_CYCLE)
);

//--- testbench/busBridgeTb.sv
`timescale 1ns/1ns
`include "busBridge_defines.svh"

module busBridgeTb;

    localparam int NUM_XFERS = 200;
    localparam int C1_PER    = 16;                      // CLK80 cycles per C1 period
    localparam int E_PER     = `E_DIV * C1_PER;
    localparam int TIMEOUT   = NUM_XFERS * 3 * E_PER + 200;

    typedef enum logic [1:0] {ownNone, ownReg, ownCia} owner_t;

    logic CLK80;
    logic RESETn;
    logic TSn;
    logic REGSPACEn;
    logic CIASPACEn;
    logic RnW;
    logic DBRn;
    logic A0;
    logic SIZ0;
    logic C1;
    logic C3;
    logic ASn;
    logic UDSn;
    logic LDSn;
    logic REGENn;
    logic VMAn;
    logic ECLK;
    logic TACK;
    logic REG_CYCLE;

    logic [3:0]  phase;
    logic [31:0] seed = 32'hdc46c3c7;
    int          cycleCount = 0;
    int          errorCount = 0;
    int          startCount = 0;
    int          tackCount = 0;
    owner_t      owner = ownNone;         // Engine expected to own the bus
    logic        tackSeen;
    logic        regCycleSeen;
    logic [1:0]  expStrobes;              // {UDSn, LDSn} expected at TACK
    logic        eclkPrev;
    int          eclkRun;
    int          eclkEdges;
    int          sinceFall;               // Cycles since the last ECLK fall

    busBridgeTop uut (
        .CLK80, .RESETn, .TSn, .REGSPACEn, .CIASPACEn, .RnW, .DBRn, .A0, .SIZ0, .C1, .C3,
        .ASn, .UDSn, .LDSn, .REGENn, .VMAn, .ECLK, .TACK, .REG_CYCLE
    );

    initial begin
        CLK80 = 1'b0;
        forever #2 CLK80 = ~CLK80;
    end

    // C1 high on phases 0..7 and C3 a quarter period behind
    initial begin
        phase = 4'd0;
        C1 <= 1'b0;
        C3 <= 1'b0;
        forever begin
            @(posedge CLK80);
            C1    <= (phase < 4'd8);
            C3    <= (phase >= 4'd4) && (phase < 4'd12);
            phase = phase + 4'd1;
        end
    end

    always @(posedge CLK80) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT) begin
            $display("Timeout after %0d cycles, a transfer never finished", cycleCount);
            $display("Starts %0d, TACKs %0d, errors %0d", startCount, tackCount, errorCount);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [15:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed[31:16];
    endfunction

    // Active-low {UDSn, LDSn}; only byte writes leave one half off
    function automatic logic [1:0] expectedStrobes(input logic rnw, input logic siz0,
                                                   input logic a0);
        if (rnw || !siz0) return 2'b00;
        else if (!a0) return 2'b01;        // Even byte on the upper half
        else return 2'b10;
    endfunction

    ////////////////////////////////////////
    // Per-cycle checks
    ////////////////////////////////////////

    task automatic checkCycle();
        int expRun;
        if (sinceFall < 1000) sinceFall++;
        if (ECLK != eclkPrev) begin
            if (eclkEdges > 0) begin               // First low stretch after reset is partial
                expRun = eclkPrev ? `E_HIGH * C1_PER : (`E_DIV - `E_HIGH) * C1_PER;
                assert (eclkRun == expRun) else begin
                    errorCount++;
                    $display("MISMATCH ECLK run at level %h: expected %h got %h",
                             eclkPrev, expRun, eclkRun);
                end
            end
            eclkEdges++;
            eclkRun = 0;
            if (!ECLK) sinceFall = 0;
        end
        eclkRun++;
        eclkPrev = ECLK;
        if (REG_CYCLE) regCycleSeen = 1'b1;
        assert (REGENn || owner == ownReg) else begin
            errorCount++;
            $display("REGENn low outside a register transfer");
        end
        assert (VMAn || owner == ownCia) else begin
            errorCount++;
            $display("VMAn low outside a CIA transfer");
        end
        assert (!REG_CYCLE || (owner == ownReg && DBRn)) else begin
            errorCount++;
            $display("REG_CYCLE high outside a register transfer or while DBRn is low");
        end
        if (TACK) begin
            tackCount++;
            assert (owner != ownNone && !tackSeen) else begin
                errorCount++;
                $display("TACK with no transfer waiting for one");
            end
            assert ({UDSn, LDSn} == expStrobes) else begin
                errorCount++;
                $display("MISMATCH UDSn/LDSn: expected %h got %h", expStrobes, {UDSn, LDSn});
            end
            assert (!ASn) else begin
                errorCount++;
                $display("MISMATCH ASn: expected %h got %h", 1'b0, ASn);
            end
            if (owner == ownReg) begin
                assert (DBRn && regCycleSeen) else begin
                    errorCount++;
                    $display("Register TACK while DBRn low or without REG_CYCLE");
                end
            end
            if (owner == ownCia) begin
                assert (sinceFall == 1) else begin
                    errorCount++;
                    $display("MISMATCH ECLK fall to TACK cycles: expected %h got %h", 1, sinceFall);
                end
            end
            tackSeen = 1'b1;
        end
    endtask

    task automatic stepCycle();
        @(posedge CLK80);
        checkCycle();
    endtask

    task automatic checkReset();
        assert (ASn && UDSn && LDSn && REGENn && VMAn) else begin
            errorCount++;
            $display("MISMATCH ASn/UDSn/LDSn/REGENn/VMAn after reset: expected %h got %h",
                     5'h1f, {ASn, UDSn, LDSn, REGENn, VMAn});
        end
        assert (!TACK && !REG_CYCLE && !ECLK) else begin
            errorCount++;
            $display("MISMATCH TACK/REG_CYCLE/ECLK after reset: expected %h got %h",
                     3'h0, {TACK, REG_CYCLE, ECLK});
        end
    endtask

    ////////////////////////////////////////
    // Random transfers
    ////////////////////////////////////////

    initial begin
        logic [15:0] r;
        logic        isCia;
        int          gap;
        int          dbrLeft;
        RESETn    <= 1'b0;
        TSn       <= 1'b1;
        REGSPACEn <= 1'b1;
        CIASPACEn <= 1'b1;
        RnW       <= 1'b1;
        DBRn      <= 1'b1;
        A0        <= 1'b0;
        SIZ0      <= 1'b0;
        tackSeen = 1'b0;
        regCycleSeen = 1'b0;
        expStrobes = 2'b00;
        eclkPrev = 1'b0;
        eclkRun = 0;
        eclkEdges = 0;
        sinceFall = 1000;
        repeat (3) @(posedge CLK80);               // RESETn low across two falling edges
        checkReset();
        RESETn <= 1'b1;
        for (int i = 0; i < NUM_XFERS; i++) begin
            r = nextRand();
            isCia = r[0];
            gap = int'(r[5:2]);
            dbrLeft = (!isCia && r[6]) ? int'(r[15:10]) : 0;   // Agnus holds the bus
            repeat (gap) stepCycle();
            TSn       <= 1'b0;
            REGSPACEn <= isCia;
            CIASPACEn <= !isCia;
            RnW       <= r[7];
            SIZ0      <= r[8];
            A0        <= r[9];
            if (dbrLeft > 0) DBRn <= 1'b0;
            expStrobes = expectedStrobes(r[7], r[8], r[9]);
            owner = isCia ? ownCia : ownReg;
            tackSeen = 1'b0;
            regCycleSeen = 1'b0;
            startCount++;
            stepCycle();
            TSn       <= 1'b1;
            REGSPACEn <= 1'b1;
            CIASPACEn <= 1'b1;
            while (!tackSeen) begin
                stepCycle();
                if (dbrLeft > 0) begin
                    dbrLeft--;
                    if (dbrLeft == 0) DBRn <= 1'b1;
                end
            end
            DBRn <= 1'b1;
            while (!ASn) stepCycle();                // Wait for the bus release
            owner = ownNone;
        end
        stepCycle();
        assert (startCount == tackCount) else begin
            errorCount++;
            $display("MISMATCH TACK count: expected %h got %h", startCount, tackCount);
        end
        assert (eclkEdges >= 4) else begin
            errorCount++;
            $display("ECLK did not toggle during the run");
        end
        $display("Starts %0d, TACKs %0d, errors %0d", startCount, tackCount, errorCount);
        if (errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+src
src/busBridgePkg.sv
src/regCycleSm.sv
src/eClockCycleSm.sv
src/busMerge.sv
src/busBridgeTop.sv
testbench/busBridge_props.sv
testbench/busBridgeTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -j 0 --top-module busBridgeTb -f project.f
./obj_dir/VbusBridgeTb 2>&1 | tee sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"
